// File: logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Architectural integer registers
`define CORE_NUM_REGS 32

`endif

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        // Operand B straight through, used by LUI
        PASS_B
    } alu_op_e;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        src_a_pc;
        logic        src_b_imm;
        logic        mem_w;
        logic        reg_w;
        logic        mem2reg;
        logic        branch;
        logic        jump;
        logic        jump_reg;
        logic [2:0]  funct3;
    } ctrl_t;

    // Data side request from the memory stage
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } mem_req_t;

endpackage

`default_nettype wire

// File: logic/decoder.sv
`default_nettype none

module decoder (
    input  wire  [31:0]      instr,
    output core_pkg::ctrl_t  ctrl,
    output logic [31:0]      imm
);
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic        alt;
    logic        funct7_ok;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? core_pkg::SUB : core_pkg::ADD;
            3'b001:  return core_pkg::SLL;
            3'b010:  return core_pkg::SLT;
            3'b011:  return core_pkg::SLTU;
            3'b100:  return core_pkg::XOR;
            3'b101:  return sub_sra ? core_pkg::SRA : core_pkg::SRL;
            3'b110:  return core_pkg::OR;
            default: return core_pkg::AND;
        endcase
    endfunction

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign alt       = instr[30];
    // Only bit 30 of funct7 may be set
    assign funct7_ok = (instr[31] == 1'b0) && (instr[29:25] == 5'd0);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = funct3;
        imm         = imm_i;
        case (opcode)
            OP_LUI, OP_AUIPC: begin
                ctrl.alu_op    = (opcode == OP_LUI) ? core_pkg::PASS_B : core_pkg::ADD;
                ctrl.src_a_pc  = (opcode == OP_AUIPC);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_w     = 1'b1;
                imm            = imm_u;
            end
            OP_JAL, OP_JALR: begin
                ctrl.jump     = (opcode == OP_JAL) || (funct3 == 3'b000);
                ctrl.jump_reg = (opcode == OP_JALR) && (funct3 == 3'b000);
                ctrl.reg_w    = ctrl.jump;
                imm           = (opcode == OP_JAL) ? imm_j : imm_i;
            end
            OP_BRANCH: begin
                // BEQ, BNE, BLT and BGE only
                ctrl.branch = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                              (funct3 == 3'b100) || (funct3 == 3'b101);
                imm         = imm_b;
            end
            OP_LOAD, OP_STORE: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem2reg   = (opcode == OP_LOAD) && (funct3 == 3'b010);
                ctrl.reg_w     = ctrl.mem2reg;
                ctrl.mem_w     = (opcode == OP_STORE) && (funct3 == 3'b010);
                imm            = (opcode == OP_STORE) ? imm_s : imm_i;
            end
            OP_IMM: begin
                ctrl.alu_op    = alu_decode(funct3, (funct3 == 3'b101) && alt);
                ctrl.src_b_imm = 1'b1;
                // Shift amounts carry a funct7 field
                ctrl.reg_w     = (funct3[1:0] != 2'b01) ||
                                 (funct7_ok && (!alt || funct3 == 3'b101));
            end
            OP_REG: begin
                ctrl.alu_op = alu_decode(funct3, alt);
                ctrl.reg_w  = funct7_ok && (!alt || funct3 == 3'b000 || funct3 == 3'b101);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`default_nettype none

module execute_unit (
    input  wire core_pkg::ctrl_t    ctrl,
    input  wire [31:0]              pc,
    input  wire [31:0]              rs1_val,
    input  wire [31:0]              rs2_val,
    input  wire [31:0]              imm,
    input  wire [31:0]              mem_fwd,
    input  wire [31:0]              wb_fwd,
    input  wire core_pkg::fwd_sel_e fwd_a,
    input  wire core_pkg::fwd_sel_e fwd_b,
    output logic [31:0]             alu_out,
    output logic [31:0]             store_data,
    output logic                    redirect,
    output logic [31:0]             target
);
    logic [31:0] a_val;
    logic [31:0] b_val;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        taken;

    function automatic logic [31:0] fwd_mux(input core_pkg::fwd_sel_e sel,
                                            input logic [31:0] reg_val,
                                            input logic [31:0] mem_val,
                                            input logic [31:0] wb_val);
        case (sel)
            core_pkg::FWD_MEM: return mem_val;
            core_pkg::FWD_WB:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    assign a_val = fwd_mux(fwd_a, rs1_val, mem_fwd, wb_fwd);
    assign b_val = fwd_mux(fwd_b, rs2_val, mem_fwd, wb_fwd);
    assign op_a  = ctrl.src_a_pc ? pc : a_val;
    assign op_b  = ctrl.src_b_imm ? imm : b_val;

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::SUB:    alu_res = op_a - op_b;
            core_pkg::AND:    alu_res = op_a & op_b;
            core_pkg::OR:     alu_res = op_a | op_b;
            core_pkg::XOR:    alu_res = op_a ^ op_b;
            core_pkg::SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            core_pkg::SLTU:   alu_res = {31'd0, op_a < op_b};
            core_pkg::SLL:    alu_res = op_a << op_b[4:0];
            core_pkg::SRL:    alu_res = op_a >> op_b[4:0];
            core_pkg::SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            core_pkg::PASS_B: alu_res = op_b;
            default:          alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (a_val == b_val);
            3'b001:  taken = (a_val != b_val);
            3'b100:  taken = $signed(a_val) < $signed(b_val);
            3'b101:  taken = $signed(a_val) >= $signed(b_val);
            default: taken = 1'b0;
        endcase
    end

    // Jumps write the link address
    assign alu_out    = ctrl.jump ? pc + 32'd4 : alu_res;
    assign store_data = b_val;
    assign redirect   = ctrl.jump || (ctrl.branch && taken);
    assign target     = ctrl.jump_reg ? ((a_val + imm) & ~32'd1) : pc + imm;

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  wire [4:0]                dec_rs1,
    input  wire [4:0]                dec_rs2,
    input  wire [4:0]                ex_rs1,
    input  wire [4:0]                ex_rs2,
    input  wire [4:0]                ex_rd,
    input  wire [4:0]                mem_rd,
    input  wire [4:0]                wb_rd,
    input  wire                      ex_mem2reg,
    input  wire                      mem_reg_w,
    input  wire                      wb_reg_w,
    input  wire                      redirect,
    input  wire                      fetch_valid,
    input  wire                      mem_valid,
    output core_pkg::fwd_sel_e       fwd_a,
    output core_pkg::fwd_sel_e       fwd_b,
    output logic                     fetch_stall,
    output logic                     exec_stall,
    output logic                     exec_flush,
    output logic                     mem_flush
);
    logic freeze;
    logic load_use;

    // Youngest producer wins
    function automatic core_pkg::fwd_sel_e fwd_pick(input logic [4:0] rs,
                                                    input logic       m_w,
                                                    input logic [4:0] m_rd,
                                                    input logic       w_w,
                                                    input logic [4:0] w_rd);
        if (m_w && m_rd != 5'd0 && m_rd == rs)
            return core_pkg::FWD_MEM;
        if (w_w && w_rd != 5'd0 && w_rd == rs)
            return core_pkg::FWD_WB;
        return core_pkg::FWD_NONE;
    endfunction

    assign fwd_a = fwd_pick(ex_rs1, mem_reg_w, mem_rd, wb_reg_w, wb_rd);
    assign fwd_b = fwd_pick(ex_rs2, mem_reg_w, mem_rd, wb_reg_w, wb_rd);

    assign freeze   = !mem_valid;
    assign load_use = ex_mem2reg && (ex_rd != 5'd0) && (ex_rd == dec_rs1 || ex_rd == dec_rs2);

    // A redirect discards the fetched word anyway, so it ignores fetch_valid
    assign fetch_stall = freeze || (!redirect && (load_use || !fetch_valid));
    assign exec_stall  = freeze;
    assign exec_flush  = !freeze && (redirect || load_use || !fetch_valid);
    // Writeback waits for the data side
    assign mem_flush   = freeze;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

`include "core_defines.svh"

module reg_file (
    input  wire         clk,
    input  wire         we,
    input  wire         hold,
    input  wire  [4:0]  waddr,
    input  wire  [4:0]  raddr_a,
    input  wire  [4:0]  raddr_b,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b
);
    logic [31:0] regs [`CORE_NUM_REGS];
    logic [4:0]  addr_a_q;
    logic [4:0]  addr_b_q;
    logic [4:0]  addr_a;
    logic [4:0]  addr_b;

    // x0 reads zero, a write in the same cycle is passed through
    function automatic logic [31:0] lookup(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;
        if (we && waddr == addr)
            return wdata;
        return regs[addr];
    endfunction

    // A stalled decode keeps re-reading its own sources so late writes are seen
    assign addr_a = hold ? addr_a_q : raddr_a;
    assign addr_b = hold ? addr_b_q : raddr_b;

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0)
            regs[waddr] <= wdata;
        addr_a_q <= addr_a;
        addr_b_q <= addr_b;
        rdata_a  <= lookup(addr_a);
        rdata_b  <= lookup(addr_b);
    end

endmodule

`default_nettype wire

// File: logic/boredcore.sv
`default_nettype none

`include "core_defines.svh"

module boredcore (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire  [31:0]         instr,
    input  wire                 fetch_valid,
    input  wire  [31:0]         rdata,
    input  wire                 mem_valid,
    output logic [31:0]         pc,
    output core_pkg::mem_req_t  data_req
);
    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    typedef struct packed {
        core_pkg::ctrl_t ctrl;
        logic [31:0]     pc;
        logic [31:0]     imm;
        logic [31:0]     rs1_val;
        logic [31:0]     rs2_val;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
    } ex_stage_t;

    typedef struct packed {
        core_pkg::ctrl_t ctrl;
        logic [31:0]     alu_out;
        logic [31:0]     store_data;
        logic [4:0]      rd;
    } mem_stage_t;

    typedef struct packed {
        core_pkg::ctrl_t ctrl;
        logic [31:0]     alu_out;
        logic [31:0]     load_data;
        logic [4:0]      rd;
    } wb_stage_t;

    logic               fetch_live;
    logic [31:0]        pc_q;
    logic [31:0]        dec_pc;
    logic [31:0]        instr_buf;
    logic [4:0]         dec_rs1;
    logic [4:0]         dec_rs2;
    logic [4:0]         dec_rd;
    core_pkg::ctrl_t    dec_ctrl;
    core_pkg::ctrl_t    dec_ctrl_w;
    logic [31:0]        dec_imm;
    logic [31:0]        rs1_rdata;
    logic [31:0]        rs2_rdata;
    logic [31:0]        dec_rs1_val;
    logic [31:0]        dec_rs2_val;
    ex_stage_t          ex_q;
    mem_stage_t         mem_q;
    wb_stage_t          wb_q;
    core_pkg::fwd_sel_e fwd_a;
    core_pkg::fwd_sel_e fwd_b;
    logic               fetch_stall;
    logic               exec_stall;
    logic               exec_flush;
    logic               mem_flush;
    logic [31:0]        alu_out;
    logic [31:0]        store_data;
    logic               redirect;
    logic [31:0]        target;
    logic [31:0]        wb_result;

    assign dec_rs1 = instr_buf[19:15];
    assign dec_rs2 = instr_buf[24:20];
    assign dec_rd  = instr_buf[11:7];

    decoder u_decoder (
        .instr (instr_buf),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm)
    );

    // Sources read from the raw fetch word, alongside the buffer load
    reg_file u_reg_file (
        .clk     (clk),
        .we      (wb_q.ctrl.reg_w),
        .hold    (fetch_stall),
        .waddr   (wb_q.rd),
        .raddr_a (instr[19:15]),
        .raddr_b (instr[24:20]),
        .wdata   (wb_result),
        .rdata_a (rs1_rdata),
        .rdata_b (rs2_rdata)
    );

    execute_unit u_execute_unit (
        .ctrl       (ex_q.ctrl),
        .pc         (ex_q.pc),
        .rs1_val    (ex_q.rs1_val),
        .rs2_val    (ex_q.rs2_val),
        .imm        (ex_q.imm),
        .mem_fwd    (mem_q.alu_out),
        .wb_fwd     (wb_result),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .alu_out    (alu_out),
        .store_data (store_data),
        .redirect   (redirect),
        .target     (target)
    );

    hazard_unit u_hazard_unit (
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .ex_rs1      (ex_q.rs1),
        .ex_rs2      (ex_q.rs2),
        .ex_rd       (ex_q.rd),
        .mem_rd      (mem_q.rd),
        .wb_rd       (wb_q.rd),
        .ex_mem2reg  (ex_q.ctrl.mem2reg),
        .mem_reg_w   (mem_q.ctrl.reg_w),
        .wb_reg_w    (wb_q.ctrl.reg_w),
        .redirect    (redirect),
        .fetch_valid (fetch_valid),
        .mem_valid   (mem_valid),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .fetch_stall (fetch_stall),
        .exec_stall  (exec_stall),
        .exec_flush  (exec_flush),
        .mem_flush   (mem_flush)
    );

    // Address for the next edge, pc_q is the word now on instr
    assign pc = (!fetch_live || fetch_stall) ? pc_q :
                redirect                     ? target :
                                               pc_q + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_live <= 1'b0;
            pc_q       <= `CORE_RESET_PC;
            dec_pc     <= `CORE_RESET_PC;
            instr_buf  <= NOP;
        end else begin
            fetch_live <= 1'b1;
            pc_q       <= pc;
            if (!fetch_stall) begin
                dec_pc    <= pc_q;
                instr_buf <= (exec_flush || !fetch_live) ? NOP : instr;
            end
        end
    end

    // No register writes to x0
    always_comb begin
        dec_ctrl_w       = dec_ctrl;
        dec_ctrl_w.reg_w = dec_ctrl.reg_w && (dec_rd != 5'd0);
    end

    // Writeback retires at the coming edge, after this decode's register read
    assign dec_rs1_val = (wb_q.ctrl.reg_w && wb_q.rd == dec_rs1) ? wb_result : rs1_rdata;
    assign dec_rs2_val = (wb_q.ctrl.reg_w && wb_q.rd == dec_rs2) ? wb_result : rs2_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_q <= '0;
        end else if (!exec_stall) begin
            if (exec_flush) begin
                ex_q <= '0;
            end else begin
                ex_q.ctrl    <= dec_ctrl_w;
                ex_q.pc      <= dec_pc;
                ex_q.imm     <= dec_imm;
                ex_q.rs1_val <= dec_rs1_val;
                ex_q.rs2_val <= dec_rs2_val;
                ex_q.rs1     <= dec_rs1;
                ex_q.rs2     <= dec_rs2;
                ex_q.rd      <= dec_rd;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_q <= '0;
        end else if (!exec_stall) begin
            mem_q.ctrl       <= ex_q.ctrl;
            mem_q.alu_out    <= alu_out;
            mem_q.store_data <= store_data;
            mem_q.rd         <= ex_q.rd;
        end
    end

    // Load data is captured straight from the data side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else if (!mem_flush) begin
            wb_q.ctrl      <= mem_q.ctrl;
            wb_q.alu_out   <= mem_q.alu_out;
            wb_q.load_data <= rdata;
            wb_q.rd        <= mem_q.rd;
        end
    end

    assign wb_result = wb_q.ctrl.mem2reg ? wb_q.load_data : wb_q.alu_out;

    assign data_req = '{addr: mem_q.alu_out, wdata: mem_q.store_data, we: mem_q.ctrl.mem_w};

endmodule

`default_nettype wire

// File: tests/core_model.sv
`default_nettype none

module core_model;
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] x [32];
    logic [31:0] exp_addr [1024];
    logic [31:0] exp_data [1024];
    int          exp_count;

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs until the closing self-jump
    task automatic run();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nxt;
        logic [31:0] ii;
        logic [31:0] is;
        logic [31:0] ib;
        logic [31:0] ij;
        logic        tk;
        pc = 32'd0;
        exp_count = 0;
        for (int i = 0; i < 32; i++) x[i] = 32'd0;
        for (int s = 0; s < 4096; s++) begin
            ins = imem[pc[9:2]];
            if (ins == 32'h0000_006f)
                break;
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            ii  = {{20{ins[31]}}, ins[31:20]};
            is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            ib  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            ij  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            nxt = pc + 32'd4;
            case (ins[6:0])
                7'h37: x[ins[11:7]] = {ins[31:12], 12'd0};
                7'h17: x[ins[11:7]] = pc + {ins[31:12], 12'd0};
                7'h6f: begin
                    x[ins[11:7]] = pc + 32'd4;
                    nxt = pc + ij;
                end
                7'h67: begin
                    nxt = (a + ii) & ~32'd1;
                    x[ins[11:7]] = pc + 32'd4;
                end
                7'h63: begin
                    case (ins[14:12])
                        3'd0:    tk = (a == b);
                        3'd1:    tk = (a != b);
                        3'd4:    tk = $signed(a) < $signed(b);
                        default: tk = $signed(a) >= $signed(b);
                    endcase
                    if (tk)
                        nxt = pc + ib;
                end
                7'h03: x[ins[11:7]] = dmem[(a + ii) >> 2 & 32'hff];
                7'h23: begin
                    dmem[(a + is) >> 2 & 32'hff] = b;
                    exp_addr[exp_count] = a + is;
                    exp_data[exp_count] = b;
                    exp_count++;
                end
                7'h13: x[ins[11:7]] = alu(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, ii);
                default: x[ins[11:7]] = alu(ins[14:12], ins[30], a, b);
            endcase
            x[0] = 32'd0;
            pc = nxt;
        end
    endtask

endmodule

`default_nettype wire

// File: tests/core_tb.sv
`default_nettype none

`include "core_defines.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS  = 4;
    localparam int PROG_WORDS = 192;
    // Index of the first dump store
    localparam int BODY_END   = 159;

    logic               clk;
    logic               arst_n;
    logic [31:0]        instr;
    logic               fetch_valid;
    logic [31:0]        rdata;
    logic               mem_valid;
    logic [31:0]        pc;
    core_pkg::mem_req_t data_req;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] pc_s;
    int          seed = 32'h1ae58999;
    int          rate;
    int          errors;
    int          checks;
    int          store_idx;
    int          drop_rate [NUM_TESTS] = '{0, 20, 40, 30};

    boredcore DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .fetch_valid (fetch_valid),
        .rdata       (rdata),
        .mem_valid   (mem_valid),
        .pc          (pc),
        .data_req    (data_req)
    );

    core_model u_model ();

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Mostly x1..x6 so that dependences are frequent
    function automatic logic [4:0] pick_reg();
        int v;
        v = rnd(8);
        return (v < 6) ? 5'(v + 1) : 5'(rnd(32));
    endfunction

    function automatic logic [31:0] gen_instr(input int i);
        logic [31:0] r;
        logic [31:0] u;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] im;
        logic [12:0] bo;
        logic [20:0] jo;
        logic        alt;
        int          k;
        r   = $random(seed);
        u   = $random(seed);
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        k   = 1 + rnd(8);
        if (i + k > BODY_END)
            k = BODY_END - i;
        alt = r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5);
        im  = {2'b00, r[28:21], 2'b00};
        bo  = 13'(k * 4);
        jo  = 21'(k * 4);
        case (rnd(10))
            0, 1: return {1'b0, alt, 5'd0, rs2, rs1, r[2:0], rd, 7'h33};
            2, 3: begin
                if (r[2:0] == 3'd1)
                    return {7'd0, r[8:4], rs1, r[2:0], rd, 7'h13};
                if (r[2:0] == 3'd5)
                    return {1'b0, r[3], 5'd0, r[8:4], rs1, r[2:0], rd, 7'h13};
                return {r[20:9], rs1, r[2:0], rd, 7'h13};
            end
            4:       return {u[31:12], rd, r[4] ? 7'h37 : 7'h17};
            5:       return {im, rs1, 3'b010, rd, 7'h03};
            6:       return {im[11:5], rs2, rs1, 3'b010, im[4:0], 7'h23};
            7: return {bo[12], bo[10:5], rs2, rs1, r[5], 1'b0, r[6], bo[4:1], bo[11], 7'h63};
            8:       return {jo[20], jo[10:1], jo[11], jo[19:12], rd, 7'h6f};
            default: return {12'((i + k) * 4), 5'd0, 3'b000, rd, 7'h67};
        endcase
    endfunction

    task automatic build_program(input int t);
        logic [11:0] off;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
            dmem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3} + 32'(t);
        end
        for (int i = 0; i < 31; i++)
            imem[i] = {12'($random(seed)), 5'd0, 3'b000, 5'(i + 1), 7'h13};
        for (int i = 31; i < BODY_END; i++)
            imem[i] = gen_instr(i);
        // Register dump from byte 0x300 and a closing self-jump
        for (int j = 0; j < 32; j++) begin
            off = 12'h300 + 12'(j * 4);
            imem[BODY_END + j] = {off[11:5], 5'(j), 5'd0, 3'b010, off[4:0], 7'h23};
        end
        imem[PROG_WORDS - 1] = 32'h0000_006f;
        for (int i = 0; i < 256; i++) begin
            u_model.imem[i] = imem[i];
            u_model.dmem[i] = dmem[i];
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        pc_s <= pc;
        if (arst_n && data_req.we && mem_valid) begin
            dmem[data_req.addr[9:2]] <= data_req.wdata;
            if (store_idx < u_model.exp_count) begin
                check("data_req.addr", data_req.addr, u_model.exp_addr[store_idx]);
                check("data_req.wdata", data_req.wdata, u_model.exp_data[store_idx]);
            end else begin
                $display("store to %h after the last expected store", data_req.addr);
                errors++;
            end
            store_idx <= store_idx + 1;
        end
    end

    always @(negedge clk) begin
        fetch_valid <= rnd(100) >= rate;
        mem_valid   <= rnd(100) >= rate;
        instr       <= imem[pc_s[9:2]];
        rdata       <= dmem[data_req.addr[9:2]];
    end

    initial begin
        #(40 * PROG_WORDS * NUM_TESTS * 8);
        $display("timeout: the program did not reach its final store in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int err_before;
        arst_n      = 1'b0;
        instr       = 32'h0000_0013;
        fetch_valid = 1'b1;
        mem_valid   = 1'b1;
        rdata       = 32'd0;
        pc_s        = 32'd0;
        rate        = 0;
        errors      = 0;
        checks      = 0;
        store_idx   = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            @(negedge clk);
            arst_n = 1'b0;
            rate   = drop_rate[t];
            build_program(t);
            u_model.run();
            store_idx = 0;
            repeat (5) @(negedge clk);
            // Reset state of the fetch address and the store strobe
            check("pc", pc, `CORE_RESET_PC);
            check("data_req.we", 32'(data_req.we), 32'd0);
            arst_n = 1'b1;
            while (store_idx < u_model.exp_count)
                @(posedge clk);
            repeat (20) @(posedge clk);
            check("store_count", 32'(store_idx), 32'(u_model.exp_count));
            $display("test %0d: drop rate %0d%%, %0d stores, %0d errors", t, rate,
                     store_idx, errors - err_before);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/core_pkg.sv
logic/decoder.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/reg_file.sv
logic/boredcore.sv
tests/core_model.sv
tests/core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f filelist.f --top-module core_tb -Mdir obj_dir
./obj_dir/Vcore_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
